//--- verilog/core_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizing constants for the core.
// Include wherever memory widths, reset
// length, queue depth or host address are needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// External line memory
`define MEMORY_ADDR_WIDTH 30  // Line address bits
`define MEMORY_LINE_WIDTH 128 // Four 32-bit words per line

`define RESET_CYCLE 8         // Internal reset cycles after rstN rises
`define INST_QUEUE_DEPTH 4    // Entries between fetch and execute

// A word store here goes to hostIoValue instead of memory
`define HOST_IO_ADDR 32'h8000_0000

`endif

//--- verilog/CoreTypes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by fetch, queue and execute.
// Opcode and ALU enums, instruction word union.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package CoreTypes;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OpcOp     = 7'b0110011, // ADD, SUB
        OpcOpImm  = 7'b0010011, // ADDI
        OpcLui    = 7'b0110111,
        OpcLoad   = 7'b0000011, // LW
        OpcStore  = 7'b0100011, // SW
        OpcSystem = 7'b1110011  // ECALL
    } OpCode;

    typedef enum logic [1:0] {
        AluAdd,
        AluSub,
        AluPass // Second operand straight through, for LUI
    } AluOp;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        OpCode       opcode;
    } ITypeFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        OpCode      opcode;
    } STypeFields;

    typedef struct packed {
        logic [6:0] funct7; // Bit 5 selects SUB
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        OpCode      opcode;
    } RTypeFields;

    // One instruction word, read through the member its opcode calls for
    typedef union packed {
        ITypeFields iType;
        STypeFields sType;
        RTypeFields rType;
    } InstWord;

endpackage

`default_nettype wire

//--- verilog/ResetSequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Holds the internal reset low while rstN is
// low and for `RESET_CYCLE cycles after it rises.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module ResetSequencer (
    input  logic clk,
    input  logic rstN,
    output logic rstInternalN
);
    localparam int CountWidth = $clog2(`RESET_CYCLE + 1);

    logic [CountWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= CountWidth'(`RESET_CYCLE); // Reload while held in reset
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign rstInternalN = (count == '0);

endmodule

`default_nettype wire

//--- verilog/MemoryAccessArbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shares the external line memory between the
// fetch and data requesters. Data wins a tie and
// the grant holds until the memory signals done.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module MemoryAccessArbiter (
    input  logic clk,
    input  logic rstN,
    // Fetch requester, read only
    input  logic fetchEnable,
    input  logic [`MEMORY_ADDR_WIDTH-1:0] fetchAddr,
    output logic [`MEMORY_LINE_WIDTH-1:0] fetchReadValue,
    output logic fetchDone,
    // Data requester
    input  logic dataEnable,
    input  logic dataIsWrite,
    input  logic [`MEMORY_ADDR_WIDTH-1:0] dataAddr,
    input  logic [`MEMORY_LINE_WIDTH-1:0] dataWriteValue,
    output logic [`MEMORY_LINE_WIDTH-1:0] dataReadValue,
    output logic dataDone,
    // External memory port
    output logic [`MEMORY_ADDR_WIDTH-1:0] memoryAddr,
    output logic memoryEnable,
    output logic memoryIsWrite,
    output logic [`MEMORY_LINE_WIDTH-1:0] memoryWriteValue,
    input  logic [`MEMORY_LINE_WIDTH-1:0] memoryReadValue,
    input  logic memoryDone
);
    logic busy;
    logic ownerIsData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            ownerIsData <= 1'b0;
        end else if (busy) begin
            if (memoryDone) begin
                busy <= 1'b0; // Free again; rearbitrate next cycle
            end
        end else if (dataEnable) begin
            busy <= 1'b1;
            ownerIsData <= 1'b1;
        end else if (fetchEnable) begin
            busy <= 1'b1;
            ownerIsData <= 1'b0;
        end
    end

    always_comb begin
        memoryEnable = busy && (ownerIsData ? dataEnable : fetchEnable);
        memoryAddr = ownerIsData ? dataAddr : fetchAddr;
        memoryIsWrite = ownerIsData && dataIsWrite; // Fetch never writes
        memoryWriteValue = dataWriteValue;

        fetchReadValue = memoryReadValue;
        dataReadValue = memoryReadValue;
        fetchDone = busy && !ownerIsData && memoryDone;
        dataDone = busy && ownerIsData && memoryDone;
    end

endmodule

`default_nettype wire

//--- verilog/FetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequential instruction fetch. Reads one line
// at a time from line 0 upward and offers its
// words in address order over valid/ready.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module FetchUnit (
    input  logic clk,
    input  logic rstN,
    output logic memEnable,
    output logic [`MEMORY_ADDR_WIDTH-1:0] memAddr,
    input  logic [`MEMORY_LINE_WIDTH-1:0] memReadValue,
    input  logic memDone,
    output logic instValid,
    input  logic instReady,
    output CoreTypes::InstWord inst
);
    localparam int WordsPerLine = `MEMORY_LINE_WIDTH / 32;
    localparam int IndexWidth = $clog2(WordsPerLine);

    logic [`MEMORY_ADDR_WIDTH-1:0] linePtr;
    logic [`MEMORY_LINE_WIDTH-1:0] lineReg;
    logic [IndexWidth-1:0] wordIdx;
    logic lineValid; // lineReg still has words to hand out

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memEnable <= 1'b0;
            lineValid <= 1'b0;
            linePtr <= '0;
            wordIdx <= '0;
        end else if (memEnable) begin
            if (memDone) begin
                memEnable <= 1'b0;
                lineValid <= 1'b1;
                wordIdx <= '0;
            end
        end else if (!lineValid) begin
            memEnable <= 1'b1; // Previous line drained, request the next
        end else if (instReady) begin
            wordIdx <= wordIdx + 1'b1;
            if (wordIdx == IndexWidth'(WordsPerLine - 1)) begin
                lineValid <= 1'b0;
                linePtr <= linePtr + 1'b1;
            end
        end
    end

    // Captures the returned line
    always_ff @(posedge clk) begin
        if (memEnable && memDone) begin
            lineReg <= memReadValue;
        end
    end

    assign memAddr = linePtr;
    assign instValid = lineValid;
    assign inst = lineReg[wordIdx*32 +: 32]; // Word 0 sits in the low bits

endmodule

`default_nettype wire

//--- verilog/InstQueue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular FIFO of instruction words between
// fetch and execute, valid/ready on both sides.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module InstQueue (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    output logic inReady,
    input  CoreTypes::InstWord inInst,
    output logic outValid,
    input  logic outReady,
    output CoreTypes::InstWord outInst
);
    localparam int Depth = `INST_QUEUE_DEPTH;
    localparam int PtrWidth = $clog2(Depth);
    localparam int CountWidth = $clog2(Depth + 1);

    CoreTypes::InstWord entries [Depth];
    logic [PtrWidth-1:0] rdPtr;
    logic [PtrWidth-1:0] wrPtr;
    logic [CountWidth-1:0] count;
    logic push;
    logic pop;

    assign inReady = (count != CountWidth'(Depth));
    assign outValid = (count != '0);
    assign push = inValid && inReady;
    assign pop = outValid && outReady;
    assign outInst = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= inInst;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ExecUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decodes and executes one instruction at a time.
// Owns the register file, does line loads and
// read-modify-write stores, host output and halt.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module ExecUnit (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    output logic instReady,
    input  CoreTypes::InstWord inst,
    output logic memEnable,
    output logic memIsWrite,
    output logic [`MEMORY_ADDR_WIDTH-1:0] memAddr,
    output logic [`MEMORY_LINE_WIDTH-1:0] memWriteValue,
    input  logic [`MEMORY_LINE_WIDTH-1:0] memReadValue,
    input  logic memDone,
    output logic [31:0] hostIoValue,
    output logic halted
);
    typedef enum logic [2:0] {Idle, LoadWait, StoreRead, StoreWrite, Halted} ExecState;

    ExecState state;
    logic [31:0] regs [32];
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immU;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] effAddr;
    CoreTypes::AluOp aluOp;
    logic accept;
    logic isAlu;
    logic regWe;
    logic [4:0] regWaddr;
    logic [31:0] regWdata;
    // Held for the memory phase of LW and SW
    logic [31:0] addrReg;
    logic [31:0] storeData;
    logic [4:0] rdReg;
    logic [`MEMORY_LINE_WIDTH-1:0] lineBuf;
    logic [31:0] loadWord;

    assign instReady = (state == Idle);
    assign accept = instValid && instReady;

    // x0 reads as zero and is never written
    assign rs1Val = (inst.rType.rs1 == 5'd0) ? 32'd0 : regs[inst.rType.rs1];
    assign rs2Val = (inst.rType.rs2 == 5'd0) ? 32'd0 : regs[inst.rType.rs2];

    always_comb begin
        immI = {{20{inst.iType.imm[11]}}, inst.iType.imm};
        immS = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
        immU = {inst.iType.imm, inst.iType.rs1, inst.iType.funct3, 12'b0};
        effAddr = rs1Val + ((inst.rType.opcode == CoreTypes::OpcStore) ? immS : immI);

        isAlu = 1'b1;
        aluOp = CoreTypes::AluAdd;
        aluB = immI; // ADDI
        case (inst.rType.opcode)
            CoreTypes::OpcOp: begin
                aluOp = inst.rType.funct7[5] ? CoreTypes::AluSub : CoreTypes::AluAdd;
                aluB = rs2Val;
            end
            CoreTypes::OpcOpImm: begin
            end
            CoreTypes::OpcLui: begin
                aluOp = CoreTypes::AluPass;
                aluB = immU;
            end
            default: isAlu = 1'b0;
        endcase

        case (aluOp)
            CoreTypes::AluAdd: aluResult = rs1Val + aluB;
            CoreTypes::AluSub: aluResult = rs1Val - aluB;
            default: aluResult = aluB;
        endcase
    end

    assign loadWord = memReadValue[addrReg[3:2]*32 +: 32];

    // One write port, shared by ALU results and load returns
    assign regWe = (accept && isAlu) || (state == LoadWait && memDone);
    assign regWaddr = (state == LoadWait) ? rdReg : inst.rType.rd;
    assign regWdata = (state == LoadWait) ? loadWord : aluResult;

    always_ff @(posedge clk) begin
        if (regWe && regWaddr != 5'd0) begin
            regs[regWaddr] <= regWdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
            hostIoValue <= '0;
        end else begin
            case (state)
                Idle: if (accept) begin
                    case (inst.rType.opcode)
                        CoreTypes::OpcLoad: state <= LoadWait;
                        CoreTypes::OpcStore: begin
                            if (effAddr == `HOST_IO_ADDR) begin
                                hostIoValue <= rs2Val; // Done in the accept cycle
                            end else begin
                                state <= StoreRead;
                            end
                        end
                        CoreTypes::OpcSystem: state <= Halted; // Any SYSTEM is ECALL
                        default: begin
                        end
                    endcase
                end
                LoadWait: if (memDone) state <= Idle;
                StoreRead: if (memDone) state <= StoreWrite;
                StoreWrite: if (memDone) state <= Idle;
                default: begin // Halted until reset
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addrReg <= effAddr;
            rdReg <= inst.rType.rd;
            storeData <= rs2Val;
        end
        if (state == StoreRead && memDone) begin
            lineBuf <= memReadValue;
            lineBuf[addrReg[3:2]*32 +: 32] <= storeData; // Merge over the fetched line
        end
    end

    assign memEnable = (state == LoadWait) || (state == StoreRead) || (state == StoreWrite);
    assign memIsWrite = (state == StoreWrite);
    assign memAddr = `MEMORY_ADDR_WIDTH'(addrReg[31:4]);
    assign memWriteValue = lineBuf;
    assign halted = (state == Halted);

endmodule

`default_nettype wire

//--- verilog/Core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the core. Fetch feeds the queue,
// the queue feeds execute, and both fetch and
// execute reach the line memory via the arbiter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module Core (
    input  logic clk,
    input  logic rstN,
    output logic [31:0] hostIoValue,
    output logic halted,
    output logic [`MEMORY_ADDR_WIDTH-1:0] memoryAddr,
    output logic memoryEnable,
    output logic memoryIsWrite,
    output logic [`MEMORY_LINE_WIDTH-1:0] memoryWriteValue,
    input  logic [`MEMORY_LINE_WIDTH-1:0] memoryReadValue,
    input  logic memoryDone
);
    logic rstInternalN;

    // Fetch to queue, and queue to execute
    logic fetchInstValid;
    logic fetchInstReady;
    CoreTypes::InstWord fetchInst;
    logic execInstValid;
    logic execInstReady;
    CoreTypes::InstWord execInst;

    // Requester sides of the arbiter
    logic fetchEnable;
    logic [`MEMORY_ADDR_WIDTH-1:0] fetchAddr;
    logic [`MEMORY_LINE_WIDTH-1:0] fetchReadValue;
    logic fetchDone;
    logic dataEnable;
    logic dataIsWrite;
    logic [`MEMORY_ADDR_WIDTH-1:0] dataAddr;
    logic [`MEMORY_LINE_WIDTH-1:0] dataWriteValue;
    logic [`MEMORY_LINE_WIDTH-1:0] dataReadValue;
    logic dataDone;

    ResetSequencer u_resetSequencer (
        .clk(clk),
        .rstN(rstN),
        .rstInternalN(rstInternalN)
    );

    FetchUnit u_fetchUnit (
        .clk(clk),
        .rstN(rstInternalN),
        .memEnable(fetchEnable),
        .memAddr(fetchAddr),
        .memReadValue(fetchReadValue),
        .memDone(fetchDone),
        .instValid(fetchInstValid),
        .instReady(fetchInstReady),
        .inst(fetchInst)
    );

    InstQueue u_instQueue (
        .clk(clk),
        .rstN(rstInternalN),
        .inValid(fetchInstValid),
        .inReady(fetchInstReady),
        .inInst(fetchInst),
        .outValid(execInstValid),
        .outReady(execInstReady),
        .outInst(execInst)
    );

    ExecUnit u_execUnit (
        .clk(clk),
        .rstN(rstInternalN),
        .instValid(execInstValid),
        .instReady(execInstReady),
        .inst(execInst),
        .memEnable(dataEnable),
        .memIsWrite(dataIsWrite),
        .memAddr(dataAddr),
        .memWriteValue(dataWriteValue),
        .memReadValue(dataReadValue),
        .memDone(dataDone),
        .hostIoValue(hostIoValue),
        .halted(halted)
    );

    MemoryAccessArbiter u_memoryAccessArbiter (
        .clk(clk),
        .rstN(rstInternalN),
        .fetchEnable(fetchEnable),
        .fetchAddr(fetchAddr),
        .fetchReadValue(fetchReadValue),
        .fetchDone(fetchDone),
        .dataEnable(dataEnable),
        .dataIsWrite(dataIsWrite),
        .dataAddr(dataAddr),
        .dataWriteValue(dataWriteValue),
        .dataReadValue(dataReadValue),
        .dataDone(dataDone),
        .memoryAddr(memoryAddr),
        .memoryEnable(memoryEnable),
        .memoryIsWrite(memoryIsWrite),
        .memoryWriteValue(memoryWriteValue),
        .memoryReadValue(memoryReadValue),
        .memoryDone(memoryDone)
    );

endmodule

`default_nettype wire

//--- tb/CoreAssert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions for the core, bound into
// Core. Covers the memory port hold rule, queue
// overflow and the sticky halt.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module CoreAssert (
    input logic clk,
    input logic rstN,
    input logic memoryEnable,
    input logic [`MEMORY_ADDR_WIDTH-1:0] memoryAddr,
    input logic memoryDone,
    input logic queueInValid,
    input logic queueInReady,
    input logic queueOutValid,
    input logic queueOutReady,
    input logic halted
);
    timeunit 1ns;
    timeprecision 1ps;

    logic queuePush;
    logic queuePop;
    logic [$clog2(`INST_QUEUE_DEPTH + 1):0] occupancy; // Counted from the link handshakes

    int errorCount = 0; // Assertion failures so far

    assign queuePush = queueInValid && queueInReady;
    assign queuePop = queueOutValid && queueOutReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            occupancy <= '0;
        end else if (queuePush && !queuePop) begin
            occupancy <= occupancy + 1'b1;
        end else if (queuePop && !queuePush) begin
            occupancy <= occupancy - 1'b1;
        end
    end

    // A request keeps its address until the memory answers
    property requestHeld;
        @(posedge clk) disable iff (!rstN)
        memoryEnable && !memoryDone |=> memoryEnable && $stable(memoryAddr);
    endproperty

    // A queue already holding a full set of words takes no more
    property noPushWhenFull;
        @(posedge clk) disable iff (!rstN)
        occupancy == `INST_QUEUE_DEPTH |-> !queuePush;
    endproperty

    property haltSticky;
        @(posedge clk) disable iff (!rstN)
        halted |=> halted;
    endproperty

    assert property (requestHeld) else begin
        $error("memory request dropped or changed before done");
        errorCount++;
    end

    assert property (noPushWhenFull) else begin
        $error("instruction queue written while full");
        errorCount++;
    end

    assert property (haltSticky) else begin
        $error("halted fell without a reset");
        errorCount++;
    end

endmodule

bind Core CoreAssert u_coreAssert (
    .clk(clk),
    .rstN(rstInternalN),
    .memoryEnable(memoryEnable),
    .memoryAddr(memoryAddr),
    .memoryDone(memoryDone),
    .queueInValid(fetchInstValid),
    .queueInReady(fetchInstReady),
    .queueOutValid(execInstValid),
    .queueOutReady(execInstReady),
    .halted(halted)
);

`default_nettype wire

//--- tb/CoreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the core. Runs each program in
// tb/core_tests.txt against a line memory model
// with random latency and checks hostIoValue.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_macros.svh"
`default_nettype none

module CoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HaltTimeout = 2000; // Cycles allowed per program
    localparam int HoldCycles = 20;    // Cycles watched after halt

    logic clk = 1'b0;
    logic rstN;
    logic [31:0] hostIoValue;
    logic halted;
    logic [`MEMORY_ADDR_WIDTH-1:0] memoryAddr;
    logic memoryEnable;
    logic memoryIsWrite;
    logic [`MEMORY_LINE_WIDTH-1:0] memoryWriteValue;
    logic [`MEMORY_LINE_WIDTH-1:0] memoryReadValue;
    logic memoryDone;

    logic [`MEMORY_LINE_WIDTH-1:0] lines [logic [`MEMORY_ADDR_WIDTH-1:0]];

    int testCount = 0;
    int failCount = 0;
    int fileErrors = 0;
    bit testFailed;

    Core u_dut (
        .clk(clk),
        .rstN(rstN),
        .hostIoValue(hostIoValue),
        .halted(halted),
        .memoryAddr(memoryAddr),
        .memoryEnable(memoryEnable),
        .memoryIsWrite(memoryIsWrite),
        .memoryWriteValue(memoryWriteValue),
        .memoryReadValue(memoryReadValue),
        .memoryDone(memoryDone)
    );

    always #50 clk = ~clk;

    function automatic logic [`MEMORY_LINE_WIDTH-1:0] readLine(
        input logic [`MEMORY_ADDR_WIDTH-1:0] lineAddr
    );
        if (lines.exists(lineAddr)) begin
            return lines[lineAddr];
        end
        return '0; // Unwritten lines read as zero
    endfunction

    task automatic storeWord(input logic [31:0] byteAddr, input logic [31:0] value);
        logic [`MEMORY_LINE_WIDTH-1:0] line;
        line = readLine(byteAddr[31:4]);
        line[byteAddr[3:2]*32 +: 32] = value;
        lines[byteAddr[31:4]] = line;
    endtask

    // Line memory, answers each access after 1 to 4 cycles
    initial begin : memoryModel
        logic pending;
        int waitLeft;
        logic reqWrite;
        logic [`MEMORY_ADDR_WIDTH-1:0] reqAddr;
        logic [`MEMORY_LINE_WIDTH-1:0] reqData;
        void'($urandom(7));
        pending = 1'b0;
        waitLeft = 0;
        memoryDone = 1'b0;
        memoryReadValue = '0;
        forever begin
            @(posedge clk);
            #1;
            memoryDone = 1'b0; // Done lasts one cycle
            if (!rstN) begin
                pending = 1'b0;
            end else if (pending) begin
                if (waitLeft > 0) begin
                    waitLeft--;
                end else begin
                    if (reqWrite) begin
                        lines[reqAddr] = reqData;
                    end else begin
                        memoryReadValue = readLine(reqAddr);
                    end
                    memoryDone = 1'b1;
                    pending = 1'b0;
                end
            end else if (memoryEnable === 1'b1) begin
                pending = 1'b1;
                waitLeft = $urandom % 4;
                reqWrite = memoryIsWrite;
                reqAddr = memoryAddr;
                reqData = memoryWriteValue;
            end
        end
    end

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s %s expected %h actual %h", testName, what, expected, actual);
            testFailed = 1'b1;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
    endtask

    task automatic runTest(input string testName, input logic [31:0] expected);
        int cycles;
        bit dropped;
        testFailed = 1'b0;
        applyReset();
        // Internal reset still holds here, so no fetch has started
        checkValue(testName, "memoryEnable after reset", 32'(0), 32'(memoryEnable));
        checkValue(testName, "halted after reset", 32'(0), 32'(halted));
        checkValue(testName, "hostIoValue after reset", 32'(0), hostIoValue);
        cycles = 0;
        while (halted !== 1'b1 && cycles < HaltTimeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("test %s: halted never rose within %0d cycles", testName, HaltTimeout);
            testFailed = 1'b1;
        end else begin
            checkValue(testName, "hostIoValue", expected, hostIoValue);
            dropped = 1'b0;
            for (cycles = 0; cycles < HoldCycles; cycles++) begin
                @(posedge clk);
                #1;
                if (halted !== 1'b1) begin
                    dropped = 1'b1;
                end
            end
            assert (!dropped) else begin
                $display("test %s: halted fell again after ECALL", testName);
                testFailed = 1'b1;
            end
            checkValue(testName, "hostIoValue after halt", expected, hostIoValue);
        end
        testCount++;
        if (testFailed) begin
            failCount++;
            $display("test %s FAILED", testName);
        end else begin
            $display("test %s ok", testName);
        end
    endtask

    initial begin : testLoop
        int fd;
        int ch;
        int assertErrors;
        string key;
        string testName;
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] instAddr;
        rstN = 1'b0;
        instAddr = '0;
        testName = "unnamed";
        fd = $fopen("tb/core_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/core_tests.txt");
            fileErrors++;
        end else begin
            while ($fscanf(fd, "%s", key) == 1) begin
                if (key.len() >= 2 && key.substr(0, 1) == "//") begin
                    ch = $fgetc(fd); // Skip the rest of a comment line
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (key == "test") begin
                    if ($fscanf(fd, "%s", testName) != 1) fileErrors++;
                    lines.delete();
                    instAddr = '0;
                end else if (key == "inst") begin
                    if ($fscanf(fd, "%h", word) != 1) fileErrors++;
                    storeWord(instAddr, word);
                    instAddr += 4;
                end else if (key == "data") begin
                    if ($fscanf(fd, "%h %h", addr, word) != 2) fileErrors++;
                    storeWord(addr, word);
                end else if (key == "expect") begin
                    if ($fscanf(fd, "%h", word) != 1) fileErrors++;
                    runTest(testName, word); // Expect closes the record
                end else begin
                    $display("unknown keyword %s in tests file", key);
                    fileErrors++;
                end
            end
            $fclose(fd);
        end
        assertErrors = u_dut.u_coreAssert.errorCount;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d, file errors %0d",
                 testCount, testCount - failCount, failCount, assertErrors, fileErrors);
        if (failCount == 0 && assertErrors == 0 && fileErrors == 0 && testCount > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- core.f
+incdir+verilog
verilog/CoreTypes.sv
verilog/ResetSequencer.sv
verilog/MemoryAccessArbiter.sv
verilog/FetchUnit.sv
verilog/InstQueue.sv
verilog/ExecUnit.sv
verilog/Core.sv
tb/CoreAssert.sv
tb/CoreTb.sv

//--- tb/core_tests.txt
// Columns: keyword, then hex fields. test <name>; inst <word>, stored from address 0 up;
// data <byte address> <word>; expect <hostIoValue>, which closes the record and runs it
test arith
inst 123450B7 // lui  x1, 0x12345
inst 67808093 // addi x1, x1, 0x678
inst FFB00113 // addi x2, x0, -5
inst 002081B3 // add  x3, x1, x2
inst 403105B3 // sub  x11, x2, x3
inst 80000537 // lui  x10, 0x80000
inst 00B52023 // sw   x11, 0(x10)
inst 00000073 // ecall
expect EDCBA988
test loadstore
data 00000100 11111111
data 00000104 22222222
data 00000108 33333333
data 0000010C 44444444
inst 10000293 // addi x5, x0, 0x100
inst 0042A303 // lw   x6, 4(x5)
inst 12330313 // addi x6, x6, 0x123
inst 0062A423 // sw   x6, 8(x5)
inst 0082A383 // lw   x7, 8(x5)
inst 0042A403 // lw   x8, 4(x5)
inst 00C2A483 // lw   x9, 12(x5)
inst 0002A603 // lw   x12, 0(x5)
inst 009406B3 // add  x13, x8, x9
inst 00C686B3 // add  x13, x13, x12
inst 40D385B3 // sub  x11, x7, x13
inst 80000537 // lui  x10, 0x80000
inst 00B52023 // sw   x11, 0(x10)
inst 00000073 // ecall
expect AAAAABCE
test longprog
inst 00100093 // addi x1, x0, 1
inst 00108133 // add  x2, x1, x1
inst 001101B3 // add  x3, x2, x1
inst 00218233 // add  x4, x3, x2
inst 003202B3 // add  x5, x4, x3
inst 00428333 // add  x6, x5, x4
inst 005303B3 // add  x7, x6, x5
inst 00638433 // add  x8, x7, x6
inst 007404B3 // add  x9, x8, x7
inst 008485B3 // add  x11, x9, x8
inst 06458593 // addi x11, x11, 100
inst 401585B3 // sub  x11, x11, x1
inst ABCDE637 // lui  x12, 0xABCDE
inst 00C585B3 // add  x11, x11, x12
inst 80000537 // lui  x10, 0x80000
inst 00B52023 // sw   x11, 0(x10)
inst 00000073 // ecall
expect ABCDE0BC
test halt
inst 05500593 // addi x11, x0, 0x55
inst 80000537 // lui  x10, 0x80000
inst 00B52023 // sw   x11, 0(x10)
inst 00000073 // ecall
inst 06600593 // addi x11, x0, 0x66, must not run
inst 00B52023 // sw   x11, 0(x10), must not run
expect 00000055
